//--- build.f
hdl/rsa_pkg.sv
hdl/rsa_prep.sv
hdl/rsa_mont.sv
hdl/rsa_core.sv
testbench/rsa_core_sva.sv
testbench/tb_rsa_core.sv

//--- build.sh
#!/bin/sh
# compile the testbench with Verilator, run it, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rsa_core \
    -f build.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0

//--- testbench/tb_rsa_core.sv
// testbench for rsa_core, random requests checked against a plain modular model
// run through build.f, prints a summary line and the final verdict
`timescale 1ns/1ns
`default_nettype none

module tb_rsa_core
    import rsa_pkg::*;
();

    localparam int          TIMEOUT_CYCLES = 200000;
    localparam int          NUM_RANDOM     = 8;
    localparam logic [31:0] SEED           = 32'h0ba3_eff1;
    // longer than one whole exponentiation
    localparam int          FULL_RUN_QUIET = 70000;

    logic      i_clk;
    logic      i_rst;
    logic      i_start;
    rsa_req_t  i_req;
    rsa_word_t o_result;
    logic      o_done;

    int        checks;
    int        value_errors;
    int        protocol_errors;
    bit        timed_out;
    rsa_word_t last_result;

    rsa_core DUT (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (i_start),
        .i_req    (i_req),
        .o_result (o_result),
        .o_done   (o_done)
    );

    always #50 i_clk = ~i_clk;

    // x * y mod m by double-and-add, msb first, x below m
    function automatic rsa_word_t mod_mul(rsa_word_t x, rsa_word_t y, rsa_word_t m);
        rsa_acc_t acc;
        int       i;
        acc = '0;
        for (i = RSA_W - 1; i >= 0; i--) begin
            acc = acc << 1;
            if (acc >= {2'b00, m}) begin
                acc = acc - {2'b00, m};
            end
            if (y[i]) begin
                acc = acc + {2'b00, x};
                if (acc >= {2'b00, m}) begin
                    acc = acc - {2'b00, m};
                end
            end
        end
        return acc[RSA_W-1:0];
    endfunction

    function automatic rsa_word_t mod_exp(rsa_word_t base, rsa_word_t e, rsa_word_t m);
        rsa_word_t res;
        rsa_word_t pw;
        int        i;
        res = rsa_word_t'(1);
        pw  = base;
        for (i = 0; i < RSA_W; i++) begin
            if (e[i]) begin
                res = mod_mul(res, pw, m);
            end
            pw = mod_mul(pw, pw, m);
        end
        return res;
    endfunction

    function automatic rsa_word_t rand_word();
        rsa_word_t w;
        int        k;
        for (k = 0; k < RSA_W / 32; k++) begin
            w[k*32 +: 32] = $urandom;
        end
        return w;
    endfunction

    // odd modulus with the top bit set, base below it
    function automatic rsa_req_t random_request();
        rsa_req_t req;
        req.n            = rand_word();
        req.n[RSA_W-1]   = 1'b1;
        req.n[0]         = 1'b1;
        req.d            = rand_word();
        req.a            = rand_word();
        if (req.a >= req.n) begin
            req.a[RSA_W-1] = 1'b0;
        end
        return req;
    endfunction

    task automatic check_result(input string name, input rsa_word_t exp, input rsa_word_t act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_done(input string name, input int exp, input int act);
        checks++;
        if (act < exp) begin
            protocol_errors++;
            $display("o_done pulse missing in %s", name);
        end else if (act > exp) begin
            protocol_errors++;
            $display("%0d unexpected o_done pulse(s) in %s", act - exp, name);
        end
    endtask

    task automatic start_request(input rsa_req_t req);
        @(negedge i_clk);
        i_req   = req;
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
    endtask

    task automatic wait_done(input string name, output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge i_clk);
            cycles++;
            if (o_done) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("timeout: no o_done within %0d cycles in %s", TIMEOUT_CYCLES, name);
            timed_out = 1'b1;
        end
    endtask

    // no further pulse and a steady result for a few cycles
    task automatic quiet_window(input string name, input int cycles, input rsa_word_t exp);
        int extra;
        extra = 0;
        repeat (cycles) begin
            @(negedge i_clk);
            if (o_done) begin
                extra++;
            end
        end
        check_done({name, " after done"}, 0, extra);
        check_result({name, " held"}, exp, o_result);
    endtask

    task automatic run_request(input string name, input rsa_req_t req);
        rsa_word_t exp;
        bit        seen;
        exp = mod_exp(req.a, req.d, req.n);
        start_request(req);
        check_result({name, " previous result"}, last_result, o_result);
        wait_done(name, seen);
        check_done(name, 1, int'(seen));
        if (seen) begin
            check_result(name, exp, o_result);
            last_result = exp;
            quiet_window(name, 8, exp);
        end
    endtask

    task automatic reset_phase();
        int pulses;
        pulses = 0;
        repeat (10) begin
            @(negedge i_clk);
            if (o_done) begin
                pulses++;
            end
            check_result("reset o_result", '0, o_result);
        end
        check_done("reset", 0, pulses);
        i_rst = 1'b1;
        quiet_window("after reset", 4, '0);
    endtask

    // second strobe lands while the core is still in prep
    task automatic busy_start();
        rsa_req_t  first;
        rsa_req_t  second;
        rsa_word_t exp;
        bit        seen;
        first  = random_request();
        second = random_request();
        exp    = mod_exp(first.a, first.d, first.n);
        start_request(first);
        repeat (40) @(negedge i_clk);
        check_result("busy previous result", last_result, o_result);
        start_request(second);
        wait_done("busy start", seen);
        check_done("busy start", 1, int'(seen));
        if (seen) begin
            check_result("busy start", exp, o_result);
            last_result = exp;
            // a strobe kept pending would finish a second run in here
            quiet_window("busy start", FULL_RUN_QUIET, exp);
        end
    endtask

    initial begin
        rsa_req_t req;
        int       k;
        void'($urandom(SEED));
        i_clk           = 1'b0;
        i_rst           = 1'b0;
        i_start         = 1'b0;
        i_req           = '0;
        checks          = 0;
        value_errors    = 0;
        protocol_errors = 0;
        timed_out       = 1'b0;
        last_result     = '0;

        reset_phase();

        req   = random_request();
        req.d = '0;
        run_request("zero exponent", req);

        if (!timed_out) begin
            req   = random_request();
            req.d = rsa_word_t'(1);
            run_request("unit exponent", req);
        end

        if (!timed_out) begin
            req      = random_request();
            req.a    = '0;
            req.d[0] = 1'b1;
            run_request("zero base", req);
        end

        for (k = 0; k < NUM_RANDOM; k++) begin
            if (!timed_out) begin
                req = random_request();
                run_request($sformatf("random %0d", k), req);
            end
        end

        if (!timed_out) begin
            busy_start();
        end

        $display("checks: %0d, value errors: %0d, protocol errors: %0d",
                 checks, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/rsa_core_sva.sv
// control checks on the exponentiation core
// attached to every rsa_core instance by the bind at the end of this file
`timescale 1ns/1ns
`default_nettype none

module rsa_core_sva
    import rsa_pkg::*;
(
    input logic      i_clk,
    input logic      i_rst,
    input logic      i_done,
    input rsa_word_t i_result,
    input logic      i_sq_start,
    input logic      i_sq_done
);

    // done is a single-cycle pulse
    property p_done_single;
        @(posedge i_clk) disable iff (!i_rst)
            i_done |=> !i_done;
    endproperty

    // result only moves together with done
    property p_result_held;
        @(posedge i_clk) disable iff (!i_rst)
            !i_done |-> $stable(i_result);
    endproperty

    property p_sq_no_overlap;
        @(posedge i_clk) disable iff (!i_rst)
            !(i_sq_start && i_sq_done);
    endproperty

    a_done_single: assert property (p_done_single)
        else $error("o_done stayed high for two cycles");

    a_result_held: assert property (p_result_held)
        else $error("o_result changed without o_done");

    a_sq_no_overlap: assert property (p_sq_no_overlap)
        else $error("squaring start and done in the same cycle");

endmodule

bind rsa_core rsa_core_sva u_sva (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_done     (o_done),
    .i_result   (o_result),
    .i_sq_start (sq_go),
    .i_sq_done  (sq_done)
);

`default_nettype wire

//--- hdl/rsa_core.sv
// top level of the modular exponentiation core, o_result = a^d mod n
// strobe i_start with i_req valid while idle, o_done pulses when o_result is new
`timescale 1ns/1ns
`default_nettype none

module rsa_core
    import rsa_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_start,
    input  rsa_req_t  i_req,
    output rsa_word_t o_result,
    output logic      o_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PREP,
        S_ISSUE,
        S_WAIT,
        S_NEXT
    } state_t;

    localparam int IDX_W = $clog2(RSA_W);

    state_t    state_r;
    bit_idx_t  bit_r;
    logic      prep_go_r;
    rsa_req_t  req_r;

    // power is in the montgomery domain, result stays plain
    rsa_word_t power_r;
    rsa_word_t result_r;

    rsa_word_t prep_res;
    logic      prep_done;
    mont_op_t  sq_op;
    mont_op_t  mul_op;
    logic      sq_go;
    logic      mul_go;
    rsa_word_t sq_res;
    rsa_word_t mul_res;
    logic      sq_done;
    logic      mul_done;
    logic      cur_bit;

    assign cur_bit = req_r.d[bit_r[IDX_W-1:0]];
    assign sq_go   = (state_r == S_ISSUE);
    assign mul_go  = sq_go && cur_bit;

    assign sq_op  = '{n: req_r.n, a: power_r, b: power_r};
    assign mul_op = '{n: req_r.n, a: result_r, b: power_r};

    rsa_prep u_prep (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (prep_go_r),
        .i_n     (req_r.n),
        .i_b     (req_r.a),
        .o_res   (prep_res),
        .o_done  (prep_done)
    );

    rsa_mont u_mont_sq (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (sq_go),
        .i_op    (sq_op),
        .o_res   (sq_res),
        .o_done  (sq_done)
    );

    rsa_mont u_mont_mul (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mul_go),
        .i_op    (mul_op),
        .o_res   (mul_res),
        .o_done  (mul_done)
    );

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            state_r   <= S_IDLE;
            bit_r     <= '0;
            prep_go_r <= 1'b0;
            o_done    <= 1'b0;
            o_result  <= '0;
        end else begin
            prep_go_r <= 1'b0;
            o_done    <= 1'b0;
            case (state_r)
                S_IDLE: begin
                    if (i_start) begin
                        state_r   <= S_PREP;
                        prep_go_r <= 1'b1;
                    end
                end
                S_PREP: begin
                    if (prep_done) begin
                        state_r <= S_ISSUE;
                        bit_r   <= '0;
                    end
                end
                S_ISSUE: begin
                    state_r <= S_WAIT;
                end
                S_WAIT: begin
                    // both products finish together
                    if (sq_done) begin
                        state_r <= S_NEXT;
                        bit_r   <= bit_r + 1'b1;
                    end
                end
                S_NEXT: begin
                    if (bit_r == bit_idx_t'(RSA_W)) begin
                        state_r  <= S_IDLE;
                        o_result <= result_r;
                        o_done   <= 1'b1;
                    end else begin
                        state_r <= S_ISSUE;
                    end
                end
                default: state_r <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == S_IDLE && i_start) begin
            req_r <= i_req;
        end
        if (state_r == S_PREP && prep_done) begin
            power_r  <= prep_res;
            result_r <= rsa_word_t'(1);
        end
        if (state_r == S_WAIT && sq_done) begin
            power_r <= sq_res;
        end
        // mul_done only comes when the exponent bit was one
        if (state_r == S_WAIT && mul_done) begin
            result_r <= mul_res;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rsa_mont.sv
// bit-serial montgomery product, o_res = a * b * 2^-RSA_W mod n
// pulse i_start with i_op valid, o_done pulses RSA_W+2 cycles later
`timescale 1ns/1ns
`default_nettype none

module rsa_mont
    import rsa_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_start,
    input  mont_op_t  i_op,
    output rsa_word_t o_res,
    output logic      o_done
);

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_RED} state_t;

    localparam int IDX_W = $clog2(RSA_W);

    state_t   state_r;
    bit_idx_t cnt_r;
    mont_op_t op_r;
    rsa_acc_t acc_r;
    rsa_acc_t acc_sum;
    rsa_acc_t acc_odd;
    rsa_acc_t acc_step;
    rsa_acc_t acc_red;

    // add b on a set multiplier bit, make the sum even with n, halve
    always_comb begin
        acc_sum = acc_r;
        if (op_r.a[cnt_r[IDX_W-1:0]]) begin
            acc_sum = acc_r + rsa_acc_t'(op_r.b);
        end
        acc_odd = acc_sum;
        if (acc_sum[0]) begin
            acc_odd = acc_sum + rsa_acc_t'(op_r.n);
        end
        acc_step = acc_odd >> 1;
    end

    // acc is below 2n here, one subtraction is enough
    always_comb begin
        acc_red = acc_r;
        if (acc_r >= rsa_acc_t'(op_r.n)) begin
            acc_red = acc_r - rsa_acc_t'(op_r.n);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            state_r <= S_IDLE;
            cnt_r   <= '0;
            o_done  <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state_r)
                S_IDLE: begin
                    if (i_start) begin
                        state_r <= S_RUN;
                        cnt_r   <= '0;
                    end
                end
                S_RUN: begin
                    cnt_r <= cnt_r + 1'b1;
                    if (cnt_r == bit_idx_t'(RSA_W - 1)) begin
                        state_r <= S_RED;
                    end
                end
                S_RED: begin
                    state_r <= S_IDLE;
                    o_done  <= 1'b1;
                end
                default: state_r <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == S_IDLE && i_start) begin
            op_r  <= i_op;
            acc_r <= '0;
        end else if (state_r == S_RUN) begin
            acc_r <= acc_step;
        end
        if (state_r == S_RED) begin
            o_res <= acc_red[RSA_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- hdl/rsa_prep.sv
// moves the base into the montgomery domain, o_res = b * 2^RSA_W mod n
// pulse i_start with operands valid, o_done pulses RSA_W+1 cycles later
`timescale 1ns/1ns
`default_nettype none

module rsa_prep
    import rsa_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_start,
    input  rsa_word_t i_n,
    input  rsa_word_t i_b,
    output rsa_word_t o_res,
    output logic      o_done
);

    typedef enum logic {S_IDLE, S_RUN} state_t;

    state_t    state_r;
    bit_idx_t  cnt_r;
    rsa_word_t n_r;
    rsa_acc_t  acc_r;
    rsa_acc_t  acc_dbl;
    rsa_acc_t  acc_next;

    // one modular doubling step, acc stays below n
    always_comb begin
        acc_dbl  = {acc_r[RSA_W:0], 1'b0};
        acc_next = acc_dbl;
        if (acc_dbl >= rsa_acc_t'(n_r)) begin
            acc_next = acc_dbl - rsa_acc_t'(n_r);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            state_r <= S_IDLE;
            cnt_r   <= '0;
            o_done  <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state_r)
                S_IDLE: begin
                    if (i_start) begin
                        state_r <= S_RUN;
                        cnt_r   <= '0;
                    end
                end
                S_RUN: begin
                    cnt_r <= cnt_r + 1'b1;
                    if (cnt_r == bit_idx_t'(RSA_W - 1)) begin
                        state_r <= S_IDLE;
                        o_done  <= 1'b1;
                    end
                end
                default: state_r <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == S_IDLE && i_start) begin
            n_r   <= i_n;
            acc_r <= rsa_acc_t'(i_b);
        end else if (state_r == S_RUN) begin
            acc_r <= acc_next;
        end
    end

    // last doubling result stays here until the next start
    assign o_res = acc_r[RSA_W-1:0];

endmodule

`default_nettype wire

//--- hdl/rsa_pkg.sv
// shared width constant and types for the rsa exponentiation core
// imported by every rtl module and by the testbench
`default_nettype none

package rsa_pkg;

    // operand width in bits
    localparam int RSA_W = 256;

    typedef logic [RSA_W-1:0] rsa_word_t;

    // partial sum plus n, two guard bits
    typedef logic [RSA_W+1:0] rsa_acc_t;

    // counts 0 to RSA_W inclusive
    typedef logic [8:0] bit_idx_t;

    // one exponentiation request
    typedef struct packed {
        rsa_word_t n;
        rsa_word_t d;
        rsa_word_t a;
    } rsa_req_t;

    // operands of one montgomery product
    typedef struct packed {
        rsa_word_t n;
        rsa_word_t a;
        rsa_word_t b;
    } mont_op_t;

endpackage

`default_nettype wire
